/* Makefile */
# Verilator build and run for the fabric controller glue

VERILATOR ?= verilator
TOP       ?= tb_fc_subsystem
RTL_TOP   ?= fc_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) src/fc_pkg.sv src/tcdm_if.sv \
	  src/fc_irq_capture.sv src/fc_l2_bridge.sv src/fc_apu_unit.sv src/fc_subsystem.sv

clean:
	rm -rf $(BUILD_DIR)

/* sim.f */
src/fc_pkg.sv
src/tcdm_if.sv
src/fc_irq_capture.sv
src/fc_l2_bridge.sv
src/fc_apu_unit.sv
src/fc_subsystem.sv
testbench/tb_fc_l2_model.sv
testbench/tb_fc_subsystem.sv

/* src/fc_apu_unit.sv */
//**************************************************************************
// Auxiliary processing unit: two-stage integer pipeline with zero and
// negative result flags, one operation accepted per cycle
//**************************************************************************

`timescale 1ns/1ps

module fc_apu_unit
  import fc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       apu_req_i,
  output logic                       apu_gnt_o,
  input  fc_apu_operands_t           apu_operands_i,
  input  fc_apu_op_e                 apu_op_i,
  output logic                       apu_rvalid_o,
  output logic [FC_DATA_W-1:0]       apu_result_o,
  output logic [FC_APU_RFLAGS_W-1:0] apu_rflags_o
);

  logic                       gnt_q;
  logic                       accept;

  // Stage one
  logic                       s1_valid_q;
  logic [FC_DATA_W-1:0]       s1_opa_q;
  logic [FC_DATA_W-1:0]       s1_opb_q;
  fc_apu_op_e                 s1_op_q;

  // Stage two
  logic                       s2_valid_q;
  logic [FC_DATA_W-1:0]       s2_result_q;
  logic [FC_APU_RFLAGS_W-1:0] s2_flags_q;

  logic [FC_DATA_W-1:0]       result_d;
  logic [FC_APU_RFLAGS_W-1:0] flags_d;

  // Grant rises on the first edge after reset and stays high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= 1'b1;
    end
  end

  assign apu_gnt_o = gnt_q;
  assign accept    = apu_req_i & gnt_q;

  //**************************************************************************
  // Valid chain
  //**************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= accept;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Operand capture, only on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      s1_opa_q <= apu_operands_i[0];
      s1_opb_q <= apu_operands_i[1];
      s1_op_q  <= apu_op_i;
    end
  end

  //**************************************************************************
  // Execute
  //**************************************************************************

  always_comb begin
    unique case (s1_op_q)
      APU_OP_ADD:  result_d = s1_opa_q + s1_opb_q;
      APU_OP_SUB:  result_d = s1_opa_q - s1_opb_q;
      APU_OP_MULL: result_d = s1_opa_q * s1_opb_q;
      APU_OP_MAX: begin
        result_d = ($signed(s1_opa_q) > $signed(s1_opb_q)) ? s1_opa_q : s1_opb_q;
      end
      default:     result_d = '0;
    endcase
  end

  always_comb begin
    flags_d                   = '0;
    flags_d[FC_APU_FLAG_ZERO] = (result_d == '0);
    flags_d[FC_APU_FLAG_NEG]  = result_d[FC_DATA_W-1];
  end

  always_ff @(posedge clk_i) begin
    if (s1_valid_q) begin
      s2_result_q <= result_d;
      s2_flags_q  <= flags_d;
    end
  end

  assign apu_rvalid_o = s2_valid_q;
  assign apu_result_o = s2_result_q;
  assign apu_rflags_o = s2_flags_q;

endmodule

/* src/fc_irq_capture.sv */
//**************************************************************************
// Interrupt capture: synchronizes peripheral events, turns rising edges
// into sticky pending bits and clears them on core acknowledge
//**************************************************************************

`timescale 1ns/1ps

module fc_irq_capture
  import fc_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [FC_N_IRQ-1:0]    events_i,
  input  logic                   irq_ack_i,
  input  logic [FC_IRQ_ID_W-1:0] irq_ack_id_i,
  output logic [FC_N_IRQ-1:0]    irq_o
);

  // Two-flop synchronizer, then a history stage for edge detection
  logic [FC_N_IRQ-1:0] meta_q;
  logic [FC_N_IRQ-1:0] sync_q;
  logic [FC_N_IRQ-1:0] prev_q;
  logic [FC_N_IRQ-1:0] rise_q;
  logic [FC_N_IRQ-1:0] irq_q;
  logic [FC_N_IRQ-1:0] ack_hit;

  // One-hot decode of the acknowledged line
  always_comb begin
    ack_hit = '0;
    if (irq_ack_i) begin
      ack_hit[irq_ack_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
      rise_q <= '0;
    end else begin
      meta_q <= events_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
      // Registered rising edge keeps the pending logic shallow
      rise_q <= sync_q & ~prev_q;
    end
  end

  //**************************************************************************
  // Pending bits
  //**************************************************************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q <= '0;
    end else begin
      for (int i = 0; i < FC_N_IRQ; i++) begin
        if (i == FC_IRQ_LEVEL_LINE) begin
          // Event generator line, no edge detect and no stickiness
          irq_q[i] <= events_i[i];
        end else if (ack_hit[i]) begin
          // Acknowledge wins over a new edge in the same cycle
          irq_q[i] <= 1'b0;
        end else begin
          irq_q[i] <= irq_q[i] | rise_q[i];
        end
      end
    end
  end

  assign irq_o = irq_q;

endmodule

/* src/fc_l2_bridge.sv */
//**************************************************************************
// Core to L2 bridge that maps the instruction and data ports onto the L2
// bus and limits the outstanding transactions on each channel
//**************************************************************************

`timescale 1ns/1ps

module fc_l2_bridge
  import fc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // Core instruction port
  input  logic                 instr_req_i,
  output logic                 instr_gnt_o,
  input  logic [FC_ADDR_W-1:0] instr_addr_i,
  output logic                 instr_rvalid_o,
  output logic [FC_DATA_W-1:0] instr_rdata_o,
  output logic                 instr_err_o,
  tcdm_if.master               l2_instr,

  // Core data port
  input  logic                 data_req_i,
  output logic                 data_gnt_o,
  input  logic [FC_ADDR_W-1:0] data_addr_i,
  input  logic                 data_we_i,
  input  logic [FC_BE_W-1:0]   data_be_i,
  input  logic [FC_DATA_W-1:0] data_wdata_i,
  output logic                 data_rvalid_o,
  output logic [FC_DATA_W-1:0] data_rdata_o,
  output logic                 data_err_o,
  tcdm_if.master               l2_data
);

  logic [FC_OUTST_W-1:0] instr_cnt_q;
  logic [FC_OUTST_W-1:0] data_cnt_q;
  logic                  instr_stall;
  logic                  data_stall;

  // Counts up on a grant and down on a response
  function automatic logic [FC_OUTST_W-1:0] outst_next(
    input logic [FC_OUTST_W-1:0] cnt,
    input logic                  granted,
    input logic                  responded
  );
    logic [FC_OUTST_W-1:0] nxt;
    nxt = cnt;
    if (granted && !responded) begin
      nxt = cnt + 1'b1;
    end else if (!granted && responded) begin
      nxt = cnt - 1'b1;
    end
    return nxt;
  endfunction

  // A response in the same cycle frees a slot at the limit
  assign instr_stall = (instr_cnt_q == FC_OUTST_W'(FC_MAX_OUTSTANDING)) && !l2_instr.r_valid;
  assign data_stall  = (data_cnt_q == FC_OUTST_W'(FC_MAX_OUTSTANDING)) && !l2_data.r_valid;

  //**************************************************************************
  // Instruction channel reads full words
  //**************************************************************************

  assign l2_instr.req   = instr_req_i & ~instr_stall;
  assign l2_instr.add   = instr_addr_i;
  assign l2_instr.wen   = 1'b1;
  assign l2_instr.wdata = '0;
  assign l2_instr.be    = '1;
  assign instr_gnt_o    = l2_instr.gnt & ~instr_stall;
  assign instr_rvalid_o = l2_instr.r_valid;
  assign instr_rdata_o  = l2_instr.r_rdata;
  assign instr_err_o    = l2_instr.r_opc;

  //**************************************************************************
  // Data channel with active-low wen toward L2
  //**************************************************************************

  assign l2_data.req    = data_req_i & ~data_stall;
  assign l2_data.add    = data_addr_i;
  assign l2_data.wen    = ~data_we_i;
  assign l2_data.wdata  = data_wdata_i;
  assign l2_data.be     = data_be_i;
  assign data_gnt_o     = l2_data.gnt & ~data_stall;
  assign data_rvalid_o  = l2_data.r_valid;
  assign data_rdata_o   = l2_data.r_rdata;
  assign data_err_o     = l2_data.r_opc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_cnt_q <= '0;
      data_cnt_q  <= '0;
    end else begin
      instr_cnt_q <= outst_next(instr_cnt_q, l2_instr.req & l2_instr.gnt, l2_instr.r_valid);
      data_cnt_q  <= outst_next(data_cnt_q, l2_data.req & l2_data.gnt, l2_data.r_valid);
    end
  end

endmodule

/* src/fc_pkg.sv */
//**************************************************************************
// Fabric controller shared definitions: bus widths, interrupt layout,
// L2 outstanding limit and the auxiliary unit operation encoding
//**************************************************************************

package fc_pkg;

  // Bus widths toward L2 and the core
  localparam int unsigned FC_ADDR_W = 32;
  localparam int unsigned FC_DATA_W = 32;
  localparam int unsigned FC_BE_W   = 4;

  //**************************************************************************
  // Interrupts
  //**************************************************************************

  localparam int unsigned FC_N_IRQ    = 32;
  localparam int unsigned FC_IRQ_ID_W = 5;

  // Event generator line, passed through as a level
  localparam int unsigned FC_IRQ_LEVEL_LINE = 11;

  //**************************************************************************
  // L2 bridge
  //**************************************************************************

  // Granted requests per channel still waiting for r_valid
  localparam int unsigned FC_MAX_OUTSTANDING = 2;
  localparam int unsigned FC_OUTST_W         = 2;

  //**************************************************************************
  // Auxiliary processing unit
  //**************************************************************************

  localparam int unsigned FC_APU_NARGS    = 2;
  localparam int unsigned FC_APU_OP_W     = 2;
  localparam int unsigned FC_APU_RFLAGS_W = 2;

  // Result flag positions
  localparam int unsigned FC_APU_FLAG_ZERO = 0;
  localparam int unsigned FC_APU_FLAG_NEG  = 1;

  typedef enum logic [FC_APU_OP_W-1:0] {
    APU_OP_ADD  = 2'b00,
    APU_OP_SUB  = 2'b01,
    // Low half of the 64-bit product
    APU_OP_MULL = 2'b10,
    // Signed maximum of the two operands
    APU_OP_MAX  = 2'b11
  } fc_apu_op_e;

  typedef logic [FC_APU_NARGS-1:0][FC_DATA_W-1:0] fc_apu_operands_t;

endpackage

/* src/fc_subsystem.sv */
//**************************************************************************
// Fabric controller glue: interrupt capture, L2 bridge and auxiliary unit
// around the control core, with the core side exposed as plain ports
//**************************************************************************

`timescale 1ns/1ps

module fc_subsystem
  import fc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Interrupts
  input  logic [FC_N_IRQ-1:0]        events_i,
  input  logic                       core_irq_ack_i,
  input  logic [FC_IRQ_ID_W-1:0]     core_irq_ack_id_i,
  output logic [FC_N_IRQ-1:0]        core_irq_o,

  // Core instruction port
  input  logic                       core_instr_req_i,
  output logic                       core_instr_gnt_o,
  input  logic [FC_ADDR_W-1:0]       core_instr_addr_i,
  output logic                       core_instr_rvalid_o,
  output logic [FC_DATA_W-1:0]       core_instr_rdata_o,
  output logic                       core_instr_err_o,

  // Core data port
  input  logic                       core_data_req_i,
  output logic                       core_data_gnt_o,
  input  logic [FC_ADDR_W-1:0]       core_data_addr_i,
  input  logic                       core_data_we_i,
  input  logic [FC_BE_W-1:0]         core_data_be_i,
  input  logic [FC_DATA_W-1:0]       core_data_wdata_i,
  output logic                       core_data_rvalid_o,
  output logic [FC_DATA_W-1:0]       core_data_rdata_o,
  output logic                       core_data_err_o,

  // Auxiliary unit
  input  logic                       apu_req_i,
  output logic                       apu_gnt_o,
  input  fc_apu_operands_t           apu_operands_i,
  input  fc_apu_op_e                 apu_op_i,
  output logic                       apu_rvalid_o,
  output logic [FC_DATA_W-1:0]       apu_result_o,
  output logic [FC_APU_RFLAGS_W-1:0] apu_rflags_o,

  // L2 instruction channel
  output logic                       l2_instr_req_o,
  output logic [FC_ADDR_W-1:0]       l2_instr_add_o,
  output logic                       l2_instr_wen_o,
  output logic [FC_DATA_W-1:0]       l2_instr_wdata_o,
  output logic [FC_BE_W-1:0]         l2_instr_be_o,
  input  logic                       l2_instr_gnt_i,
  input  logic                       l2_instr_r_valid_i,
  input  logic [FC_DATA_W-1:0]       l2_instr_r_rdata_i,
  input  logic                       l2_instr_r_opc_i,

  // L2 data channel
  output logic                       l2_data_req_o,
  output logic [FC_ADDR_W-1:0]       l2_data_add_o,
  output logic                       l2_data_wen_o,
  output logic [FC_DATA_W-1:0]       l2_data_wdata_o,
  output logic [FC_BE_W-1:0]         l2_data_be_o,
  input  logic                       l2_data_gnt_i,
  input  logic                       l2_data_r_valid_i,
  input  logic [FC_DATA_W-1:0]       l2_data_r_rdata_i,
  input  logic                       l2_data_r_opc_i
);

  tcdm_if l2_instr_bus ();
  tcdm_if l2_data_bus ();

  //**************************************************************************
  // L2 bus to plain ports
  //**************************************************************************

  assign l2_instr_req_o           = l2_instr_bus.req;
  assign l2_instr_add_o           = l2_instr_bus.add;
  assign l2_instr_wen_o           = l2_instr_bus.wen;
  assign l2_instr_wdata_o         = l2_instr_bus.wdata;
  assign l2_instr_be_o            = l2_instr_bus.be;
  assign l2_instr_bus.gnt         = l2_instr_gnt_i;
  assign l2_instr_bus.r_valid     = l2_instr_r_valid_i;
  assign l2_instr_bus.r_rdata     = l2_instr_r_rdata_i;
  assign l2_instr_bus.r_opc       = l2_instr_r_opc_i;

  assign l2_data_req_o            = l2_data_bus.req;
  assign l2_data_add_o            = l2_data_bus.add;
  assign l2_data_wen_o            = l2_data_bus.wen;
  assign l2_data_wdata_o          = l2_data_bus.wdata;
  assign l2_data_be_o             = l2_data_bus.be;
  assign l2_data_bus.gnt          = l2_data_gnt_i;
  assign l2_data_bus.r_valid      = l2_data_r_valid_i;
  assign l2_data_bus.r_rdata      = l2_data_r_rdata_i;
  assign l2_data_bus.r_opc        = l2_data_r_opc_i;

  //**************************************************************************
  // Blocks
  //**************************************************************************

  fc_irq_capture u_irq_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .events_i     (events_i),
    .irq_ack_i    (core_irq_ack_i),
    .irq_ack_id_i (core_irq_ack_id_i),
    .irq_o        (core_irq_o)
  );

  fc_l2_bridge u_l2_bridge (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (core_instr_req_i),
    .instr_gnt_o    (core_instr_gnt_o),
    .instr_addr_i   (core_instr_addr_i),
    .instr_rvalid_o (core_instr_rvalid_o),
    .instr_rdata_o  (core_instr_rdata_o),
    .instr_err_o    (core_instr_err_o),
    .l2_instr       (l2_instr_bus.master),
    .data_req_i     (core_data_req_i),
    .data_gnt_o     (core_data_gnt_o),
    .data_addr_i    (core_data_addr_i),
    .data_we_i      (core_data_we_i),
    .data_be_i      (core_data_be_i),
    .data_wdata_i   (core_data_wdata_i),
    .data_rvalid_o  (core_data_rvalid_o),
    .data_rdata_o   (core_data_rdata_o),
    .data_err_o     (core_data_err_o),
    .l2_data        (l2_data_bus.master)
  );

  fc_apu_unit u_apu_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .apu_req_i      (apu_req_i),
    .apu_gnt_o      (apu_gnt_o),
    .apu_operands_i (apu_operands_i),
    .apu_op_i       (apu_op_i),
    .apu_rvalid_o   (apu_rvalid_o),
    .apu_result_o   (apu_result_o),
    .apu_rflags_o   (apu_rflags_o)
  );

endmodule

/* src/tcdm_if.sv */
//**************************************************************************
// L2 request/grant/response bus between the bridge and the interconnect
//**************************************************************************

`timescale 1ns/1ps

interface tcdm_if
  import fc_pkg::*;
();

  // Request phase, driven by the master
  logic                 req;
  logic [FC_ADDR_W-1:0] add;
  logic                 wen;
  logic [FC_DATA_W-1:0] wdata;
  logic [FC_BE_W-1:0]   be;

  // Grant and response phase, driven by the slave
  logic                 gnt;
  logic                 r_valid;
  logic [FC_DATA_W-1:0] r_rdata;
  logic                 r_opc;

  modport master (
    output req, add, wen, wdata, be,
    input  gnt, r_valid, r_rdata, r_opc
  );

  modport slave (
    input  req, add, wen, wdata, be,
    output gnt, r_valid, r_rdata, r_opc
  );

endinterface

/* testbench/tb_fc_l2_model.sv */
//**************************************************************************
// L2 memory model: random grant stalls, in-order responses and an error
// for addresses beyond the memory
//**************************************************************************

`timescale 1ns/1ps

module tb_fc_l2_model
  import fc_pkg::*;
#(
  parameter logic [31:0] FILL_BASE = 32'h0,
  parameter int unsigned WORDS     = 1024
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 slow_i,
  input  logic                 req_i,
  input  logic [FC_ADDR_W-1:0] add_i,
  input  logic                 wen_i,
  input  logic [FC_DATA_W-1:0] wdata_i,
  input  logic [FC_BE_W-1:0]   be_i,
  output logic                 gnt_o,
  output logic                 r_valid_o,
  output logic [FC_DATA_W-1:0] r_rdata_o,
  output logic                 r_opc_o
);

  logic [FC_DATA_W-1:0] mem [WORDS];
  logic [FC_DATA_W-1:0] rdata_q [$];
  logic                 err_q [$];
  int unsigned          idx;
  logic                 in_range;

  // Fill word depends on the whole word index
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = FILL_BASE ^ (i * 32'h9e37_79b1);
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o     <= 1'b0;
      r_valid_o <= 1'b0;
      r_rdata_o <= '0;
      r_opc_o   <= 1'b0;
      rdata_q.delete();
      err_q.delete();
    end else begin
      r_valid_o <= 1'b0;
      // Responses of earlier grants only, so at least one cycle of latency
      if (rdata_q.size() > 0 && (!slow_i || $urandom_range(3) == 0)) begin
        r_valid_o <= 1'b1;
        r_rdata_o <= rdata_q.pop_front();
        r_opc_o   <= err_q.pop_front();
      end
      if (req_i && gnt_o) begin
        in_range = add_i < WORDS * 4;
        idx      = add_i[31:2] % WORDS;
        if (in_range && !wen_i) begin
          for (int b = 0; b < FC_BE_W; b++) begin
            if (be_i[b]) mem[idx][8*b+:8] = wdata_i[8*b+:8];
          end
        end
        rdata_q.push_back(in_range ? mem[idx] : '0);
        err_q.push_back(!in_range);
      end
      gnt_o <= ($urandom_range(3) != 0);
    end
  end

endmodule

/* testbench/tb_fc_subsystem.sv */
//**************************************************************************
// Testbench for the fabric controller glue that plays the core and checks
// L2 traffic, interrupts and auxiliary results against reference models
//**************************************************************************

`timescale 1ns/1ps

module tb_fc_subsystem
  import fc_pkg::*;
();

  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned MEM_WORDS  = 1024;
  localparam logic [31:0] DATA_BASE  = 32'h5a00_1000;
  localparam logic [31:0] INSTR_BASE = 32'h3c00_0000;
  localparam int unsigned N_DATA     = 40;
  localparam int unsigned N_INSTR    = 24;
  localparam int unsigned N_SLOW     = 16;
  localparam int unsigned N_IRQ_TEST = 6;
  localparam int unsigned N_APU      = 32;
  // Slow responses take about four cycles and irq tests about fifteen
  localparam int unsigned N_TXN      = 2 * N_DATA + N_INSTR + 2 * N_SLOW + N_APU;
  localparam int unsigned TIMEOUT_NS = (N_TXN * 12 + N_IRQ_TEST * 20 + 100) * CLK_PERIOD;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic slow;
  logic [FC_N_IRQ-1:0] events_i;
  logic core_irq_ack_i;
  logic [FC_IRQ_ID_W-1:0] core_irq_ack_id_i;
  logic [FC_N_IRQ-1:0] core_irq_o;
  logic core_instr_req_i;
  logic core_instr_gnt_o;
  logic core_instr_rvalid_o;
  logic core_instr_err_o;
  logic [FC_ADDR_W-1:0] core_instr_addr_i;
  logic [FC_DATA_W-1:0] core_instr_rdata_o;
  logic core_data_req_i;
  logic core_data_gnt_o;
  logic core_data_we_i;
  logic core_data_rvalid_o;
  logic core_data_err_o;
  logic [FC_ADDR_W-1:0] core_data_addr_i;
  logic [FC_BE_W-1:0] core_data_be_i;
  logic [FC_DATA_W-1:0] core_data_wdata_i;
  logic [FC_DATA_W-1:0] core_data_rdata_o;
  logic apu_req_i;
  logic apu_gnt_o;
  logic apu_rvalid_o;
  fc_apu_operands_t apu_operands_i;
  fc_apu_op_e apu_op_i;
  logic [FC_DATA_W-1:0] apu_result_o;
  logic [FC_APU_RFLAGS_W-1:0] apu_rflags_o;
  logic l2_instr_req_o;
  logic l2_instr_wen_o;
  logic l2_instr_gnt_i;
  logic l2_instr_r_valid_i;
  logic l2_instr_r_opc_i;
  logic [FC_ADDR_W-1:0] l2_instr_add_o;
  logic [FC_DATA_W-1:0] l2_instr_wdata_o;
  logic [FC_DATA_W-1:0] l2_instr_r_rdata_i;
  logic [FC_BE_W-1:0] l2_instr_be_o;
  logic l2_data_req_o;
  logic l2_data_wen_o;
  logic l2_data_gnt_i;
  logic l2_data_r_valid_i;
  logic l2_data_r_opc_i;
  logic [FC_ADDR_W-1:0] l2_data_add_o;
  logic [FC_DATA_W-1:0] l2_data_wdata_o;
  logic [FC_DATA_W-1:0] l2_data_r_rdata_i;
  logic [FC_BE_W-1:0] l2_data_be_o;

  int errors = 0;
  int instr_outst = 0;
  int data_outst = 0;
  logic [FC_DATA_W-1:0] data_shadow [MEM_WORDS];

  // Expected responses in issue order
  logic [FC_DATA_W-1:0] data_exp_q [$];
  logic data_err_q [$];
  logic data_chk_q [$];
  logic [FC_DATA_W-1:0] instr_exp_q [$];
  logic [FC_APU_RFLAGS_W+FC_DATA_W-1:0] apu_exp_q [$];
  longint apu_time_q [$];

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  fc_subsystem u_fc_subsystem (.*);

  tb_fc_l2_model #(.FILL_BASE(INSTR_BASE), .WORDS(MEM_WORDS)) u_l2_instr (
    .clk_i (clk_i), .rst_ni (rst_ni), .slow_i (slow),
    .req_i (l2_instr_req_o), .add_i (l2_instr_add_o), .wen_i (l2_instr_wen_o),
    .wdata_i (l2_instr_wdata_o), .be_i (l2_instr_be_o), .gnt_o (l2_instr_gnt_i),
    .r_valid_o (l2_instr_r_valid_i), .r_rdata_o (l2_instr_r_rdata_i),
    .r_opc_o (l2_instr_r_opc_i)
  );

  tb_fc_l2_model #(.FILL_BASE(DATA_BASE), .WORDS(MEM_WORDS)) u_l2_data (
    .clk_i (clk_i), .rst_ni (rst_ni), .slow_i (slow),
    .req_i (l2_data_req_o), .add_i (l2_data_add_o), .wen_i (l2_data_wen_o),
    .wdata_i (l2_data_wdata_o), .be_i (l2_data_be_o), .gnt_o (l2_data_gnt_i),
    .r_valid_o (l2_data_r_valid_i), .r_rdata_o (l2_data_r_rdata_i),
    .r_opc_o (l2_data_r_opc_i)
  );

  //**************************************************************************
  // Reference models
  //**************************************************************************

  function automatic logic [31:0] fill_word(input logic [31:0] base, input int unsigned idx);
    return base ^ (idx * 32'h9e37_79b1);
  endfunction

  function automatic logic [31:0] data_read_ref(input logic [31:0] addr);
    return data_shadow[addr[11:2]];
  endfunction

  // Flags above the result
  function automatic logic [33:0] apu_ref(input logic [31:0] a, input logic [31:0] b,
                                          input logic [1:0] op);
    logic [31:0] r;
    case (op)
      2'd0: r = a + b;
      2'd1: r = a - b;
      2'd2: r = a * b;
      default: r = ($signed(a) > $signed(b)) ? a : b;
    endcase
    return {r[31], (r == 32'd0), r};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  //**************************************************************************
  // Core side drivers entered and left 1 ns after a rising edge
  //**************************************************************************

  task automatic data_issue(input logic we, input logic [31:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata);
    logic in_range;
    in_range = addr < MEM_WORDS * 4;
    core_data_req_i   = 1'b1;
    core_data_we_i    = we;
    core_data_addr_i  = addr;
    core_data_be_i    = be;
    core_data_wdata_i = wdata;
    do @(posedge clk_i); while (!core_data_gnt_o);
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) data_shadow[addr[11:2]][8*b+:8] = wdata[8*b+:8];
      end
    end
    data_exp_q.push_back(in_range ? data_read_ref(addr) : '0);
    data_err_q.push_back(!in_range);
    data_chk_q.push_back(!we && in_range);
    #1;
    core_data_req_i = 1'b0;
  endtask

  task automatic instr_issue(input logic [31:0] addr);
    core_instr_req_i  = 1'b1;
    core_instr_addr_i = addr;
    do @(posedge clk_i); while (!core_instr_gnt_o);
    instr_exp_q.push_back(fill_word(INSTR_BASE, addr[11:2]));
    #1;
    core_instr_req_i = 1'b0;
  endtask

  task automatic drain();
    while (data_exp_q.size() || instr_exp_q.size() || apu_exp_q.size()) begin
      @(posedge clk_i);
    end
    #1;
  endtask

  //**************************************************************************
  // Compare process
  //**************************************************************************

  always @(posedge clk_i) begin : compare
    logic [33:0] e;
    if (rst_ni) begin
      if (l2_instr_req_o && l2_instr_gnt_i) begin
        check("instr wen", 1, l2_instr_wen_o);
        check("instr be", 4'hf, l2_instr_be_o);
        check("instr wdata", 0, l2_instr_wdata_o);
      end
      instr_outst += (l2_instr_req_o && l2_instr_gnt_i) - l2_instr_r_valid_i;
      data_outst  += (l2_data_req_o && l2_data_gnt_i) - l2_data_r_valid_i;
      check("instr outstanding limit", 1, instr_outst <= FC_MAX_OUTSTANDING);
      check("data outstanding limit", 1, data_outst <= FC_MAX_OUTSTANDING);
      if (core_data_rvalid_o) begin
        if (data_exp_q.size() == 0) begin
          errors++;
          $display("Data response arrived with no request pending");
        end else begin
          e = data_exp_q.pop_front();
          check("data err", data_err_q.pop_front(), core_data_err_o);
          if (data_chk_q.pop_front()) check("data read", e[31:0], core_data_rdata_o);
        end
      end
      if (core_instr_rvalid_o) begin
        if (instr_exp_q.size() == 0) begin
          errors++;
          $display("Instruction response arrived with no fetch pending");
        end else begin
          check("instr fetch", instr_exp_q.pop_front(), core_instr_rdata_o);
          check("instr err", 0, core_instr_err_o);
        end
      end
      if (apu_rvalid_o) begin
        if (apu_exp_q.size() == 0) begin
          errors++;
          $display("Auxiliary result arrived with no operation pending");
        end else begin
          e = apu_exp_q.pop_front();
          check("apu result", e[31:0], apu_result_o);
          check("apu flags", e[33:32], apu_rflags_o);
          check("apu latency", apu_time_q.pop_front() + 2 * CLK_PERIOD, $time);
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, a handshake never completed", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

  //**************************************************************************
  // Main sequence
  //**************************************************************************

  initial begin : main
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0] op;
    int unsigned line;
    int k;
    void'($urandom(32'h71e0_e8d1));
    for (int i = 0; i < MEM_WORDS; i++) data_shadow[i] = fill_word(DATA_BASE, i);
    rst_ni = 1'b0;
    slow = 1'b0;
    events_i = '0;
    core_irq_ack_i = 1'b0;
    core_irq_ack_id_i = '0;
    core_instr_req_i = 1'b0;
    core_instr_addr_i = '0;
    core_data_req_i = 1'b0;
    core_data_we_i = 1'b0;
    core_data_addr_i = '0;
    core_data_be_i = '0;
    core_data_wdata_i = '0;
    apu_req_i = 1'b0;
    apu_operands_i = '0;
    apu_op_i = APU_OP_ADD;
    repeat (3) @(posedge clk_i);
    check("reset irq", 0, core_irq_o);
    check("reset apu rvalid", 0, apu_rvalid_o);
    check("reset l2 req", 0, {l2_instr_req_o, l2_data_req_o});
    check("reset core gnt", 0, {core_instr_gnt_o, core_data_gnt_o});
    #1 rst_ni = 1'b1;

    // Data writes then reads and one read beyond the memory
    for (int i = 0; i < N_DATA; i++) begin
      data_issue(1'b1, $urandom_range(63) * 4, $urandom_range(15), $urandom);
    end
    for (int i = 0; i < N_DATA; i++) data_issue(1'b0, $urandom_range(63) * 4, 4'hf, '0);
    data_issue(1'b0, 32'h0001_0000, 4'hf, '0);
    drain();

    // Instruction fetches
    for (int i = 0; i < N_INSTR; i++) instr_issue($urandom_range(MEM_WORDS - 1) * 4);
    drain();

    // Slow responses on both channels at once
    slow = 1'b1;
    fork
      for (int i = 0; i < N_SLOW; i++) instr_issue($urandom_range(255) * 4);
      for (int i = 0; i < N_SLOW; i++) data_issue(1'b0, $urandom_range(63) * 4, 4'hf, '0);
    join
    drain();
    slow = 1'b0;

    // Edge interrupts
    for (int t = 0; t < N_IRQ_TEST; t++) begin
      line = $urandom_range(FC_N_IRQ - 1);
      if (line == FC_IRQ_LEVEL_LINE) line = line + 1;
      events_i[line] = 1'b1;
      @(posedge clk_i);
      #1 events_i[line] = 1'b0;
      k = 0;
      while (!core_irq_o[line] && k < 5) begin
        @(posedge clk_i);
        k++;
      end
      check("irq set", 1, core_irq_o[line]);
      repeat (3) @(posedge clk_i);
      check("irq sticky", 1, core_irq_o[line]);
      #1;
      core_irq_ack_i = 1'b1;
      core_irq_ack_id_i = line;
      @(posedge clk_i);
      #1 core_irq_ack_i = 1'b0;
      @(posedge clk_i);
      check("irq cleared", 0, core_irq_o[line]);
      #1;
    end

    // Level line has one register stage and ignores acknowledges
    events_i[FC_IRQ_LEVEL_LINE] = 1'b1;
    core_irq_ack_i = 1'b1;
    core_irq_ack_id_i = FC_IRQ_LEVEL_LINE;
    @(posedge clk_i);
    check("level delay", 0, core_irq_o[FC_IRQ_LEVEL_LINE]);
    @(posedge clk_i);
    check("level high", 1, core_irq_o[FC_IRQ_LEVEL_LINE]);
    #1 events_i[FC_IRQ_LEVEL_LINE] = 1'b0;
    core_irq_ack_i = 1'b0;
    repeat (2) @(posedge clk_i);
    check("level low", 0, core_irq_o[FC_IRQ_LEVEL_LINE]);
    #1;

    // Back-to-back auxiliary operations
    for (int i = 0; i < N_APU; i++) begin
      a = $urandom;
      b = ($urandom_range(7) == 0) ? a : $urandom;
      op = $urandom_range(3);
      apu_req_i = 1'b1;
      apu_operands_i = {b, a};
      apu_op_i = fc_apu_op_e'(op);
      do @(posedge clk_i); while (!apu_gnt_o);
      apu_exp_q.push_back(apu_ref(a, b, op));
      apu_time_q.push_back($time);
      #1;
    end
    apu_req_i = 1'b0;
    drain();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
